// ==== design/cpuMacros.svh ====
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

`define DATA_W   8
`define ADDR_W   16
`define RESET_PC 16'h0000

// Register-only opcodes
`define OP_NOP     8'h00
`define OP_CLA     8'h01
`define OP_INA     8'h02
`define OP_DCA     8'h03
`define OP_CPA     8'h04
`define OP_ROL     8'h05
`define OP_ROR     8'h06
`define OP_CLC     8'h07
`define OP_SEC     8'h08

`define OP_LDA_IMM 8'h10 // Two byte forms
`define OP_ADD_IMM 8'h11
`define OP_SUB_IMM 8'h12
`define OP_AND_IMM 8'h13
`define OP_ORA_IMM 8'h14

// Absolute, low address byte first
`define OP_LDA     8'h20
`define OP_STA     8'h21
`define OP_ADD     8'h22
`define OP_SUB     8'h23
`define OP_AND     8'h24
`define OP_ORA     8'h25
`define OP_JMP     8'h26

`define OP_BCC     8'h30 // Relative branches
`define OP_BCS     8'h31
`define OP_BEQ     8'h32
`define OP_BNE     8'h33
`define OP_BMI     8'h34
`define OP_BPL     8'h35
`define OP_BVC     8'h36
`define OP_BVS     8'h37

`define OP_HLT     8'hFF

`endif

// ==== design/cpuPkg.sv ====
`default_nettype none
`include "cpuMacros.svh"

package cpuPkg;

  typedef logic [`DATA_W-1:0] dataT;
  typedef logic [`ADDR_W-1:0] addrT;

  typedef struct packed {
    logic carry;
    logic zero;
    logic negative;
    logic overflow;
  } flagsT;

  typedef logic [3:0] aluOpT;
  localparam aluOpT ALU_PASS = 4'd0;
  localparam aluOpT ALU_LOAD = 4'd1;
  localparam aluOpT ALU_ADD  = 4'd2;
  localparam aluOpT ALU_SUB  = 4'd3;
  localparam aluOpT ALU_AND  = 4'd4;
  localparam aluOpT ALU_OR   = 4'd5;
  localparam aluOpT ALU_INC  = 4'd6;
  localparam aluOpT ALU_DEC  = 4'd7;
  localparam aluOpT ALU_CPL  = 4'd8;
  localparam aluOpT ALU_ROL  = 4'd9;
  localparam aluOpT ALU_ROR  = 4'd10;
  localparam aluOpT ALU_CLR  = 4'd11;
  localparam aluOpT ALU_SEC  = 4'd12;
  localparam aluOpT ALU_CLC  = 4'd13;

  typedef logic [2:0] instrClassT;
  localparam instrClassT CLS_INH     = 3'd0;
  localparam instrClassT CLS_IMM     = 3'd1;
  localparam instrClassT CLS_ABSRD   = 3'd2;
  localparam instrClassT CLS_ABSST   = 3'd3;
  localparam instrClassT CLS_JMP     = 3'd4;
  localparam instrClassT CLS_BRANCH  = 3'd5;
  localparam instrClassT CLS_HALT    = 3'd6;
  localparam instrClassT CLS_ILLEGAL = 3'd7;

  // Flag picked by a branch
  localparam logic [2:0] COND_CARRY = 3'd0;
  localparam logic [2:0] COND_ZERO  = 3'd1;
  localparam logic [2:0] COND_NEG   = 3'd2;
  localparam logic [2:0] COND_OVF   = 3'd3;

  typedef struct packed {
    instrClassT instrClass;
    aluOpT      aluOp;
    logic       writesAcc;
    logic [2:0] condSel;
    logic       condPol;   // Taken when flag equals this
  } ctrlT;

  typedef struct packed {
    addrT addr;
    dataT wrData;
    logic write;
  } memReqT;

  typedef enum logic [3:0] {
    FETCH,
    WAITOP,
    DECODE,
    OPLO,
    OPHI,
    DATARD,
    STORE,
    BRANCH,
    HALTED
  } seqStateT;

endpackage

`default_nettype wire

// ==== design/instrDecode.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "cpuMacros.svh"

module instrDecode (
  input  logic         CLK,
  input  logic         rst,
  input  logic         opLoad,
  input  cpuPkg::dataT opByte,
  output cpuPkg::ctrlT ctrl
);
  import cpuPkg::*;

  dataT       ir;
  instrClassT instrClass;
  aluOpT      aluOp;
  logic       writesAcc;
  logic [2:0] condSel;
  logic       condPol;

  always_ff @(posedge CLK) begin
    if (rst)
      ir <= `OP_NOP; // Lets the first DECODE fall through to FETCH
    else if (opLoad)
      ir <= opByte;
  end

  always_comb begin
    case (ir)
      `OP_NOP, `OP_CLA, `OP_INA, `OP_DCA, `OP_CPA,
      `OP_ROL, `OP_ROR, `OP_CLC, `OP_SEC:           instrClass = CLS_INH;
      `OP_LDA_IMM, `OP_ADD_IMM, `OP_SUB_IMM,
      `OP_AND_IMM, `OP_ORA_IMM:                     instrClass = CLS_IMM;
      `OP_LDA, `OP_ADD, `OP_SUB, `OP_AND, `OP_ORA: instrClass = CLS_ABSRD;
      `OP_STA:                                      instrClass = CLS_ABSST;
      `OP_JMP:                                      instrClass = CLS_JMP;
      `OP_BCC, `OP_BCS, `OP_BEQ, `OP_BNE,
      `OP_BMI, `OP_BPL, `OP_BVC, `OP_BVS:           instrClass = CLS_BRANCH;
      `OP_HLT:                                      instrClass = CLS_HALT;
      default:                                      instrClass = CLS_ILLEGAL;
    endcase
  end

  always_comb begin
    case (ir)
      `OP_LDA_IMM, `OP_LDA: aluOp = ALU_LOAD;
      `OP_ADD_IMM, `OP_ADD: aluOp = ALU_ADD;
      `OP_SUB_IMM, `OP_SUB: aluOp = ALU_SUB;
      `OP_AND_IMM, `OP_AND: aluOp = ALU_AND;
      `OP_ORA_IMM, `OP_ORA: aluOp = ALU_OR;
      `OP_INA:              aluOp = ALU_INC;
      `OP_DCA:              aluOp = ALU_DEC;
      `OP_CPA:              aluOp = ALU_CPL;
      `OP_ROL:              aluOp = ALU_ROL;
      `OP_ROR:              aluOp = ALU_ROR;
      `OP_CLA:              aluOp = ALU_CLR;
      `OP_SEC:              aluOp = ALU_SEC;
      `OP_CLC:              aluOp = ALU_CLC;
      default:              aluOp = ALU_PASS;
    endcase
  end

  // Carry-only and no-op forms keep the accumulator
  assign writesAcc = (aluOp != ALU_PASS) && (aluOp != ALU_SEC) && (aluOp != ALU_CLC);

  always_comb begin
    case (ir)
      `OP_BCS: {condSel, condPol} = {COND_CARRY, 1'b1};
      `OP_BEQ: {condSel, condPol} = {COND_ZERO, 1'b1};
      `OP_BNE: {condSel, condPol} = {COND_ZERO, 1'b0};
      `OP_BMI: {condSel, condPol} = {COND_NEG, 1'b1};
      `OP_BPL: {condSel, condPol} = {COND_NEG, 1'b0};
      `OP_BVC: {condSel, condPol} = {COND_OVF, 1'b0};
      `OP_BVS: {condSel, condPol} = {COND_OVF, 1'b1};
      default: {condSel, condPol} = {COND_CARRY, 1'b0}; // BCC
    endcase
  end

  assign ctrl = '{
    instrClass: instrClass,
    aluOp:      aluOp,
    writesAcc:  writesAcc,
    condSel:    condSel,
    condPol:    condPol
  };

endmodule

`default_nettype wire

// ==== design/aluExecute.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "cpuMacros.svh"

module aluExecute (
  input  logic          CLK,
  input  logic          rst,
  input  logic          exec,
  input  cpuPkg::dataT  operand,
  input  cpuPkg::ctrlT  ctrl,
  output cpuPkg::dataT  acc,
  output cpuPkg::flagsT flags
);
  import cpuPkg::*;

  logic [`DATA_W:0] sum;
  logic [`DATA_W:0] diff;
  logic             accSign;
  logic             opSign;
  dataT             result;
  flagsT            nextFlags;

  assign accSign = acc[`DATA_W-1];
  assign opSign = operand[`DATA_W-1];

  // Ninth bit is carry out, or borrow for subtract
  assign sum = {1'b0, acc} + {1'b0, operand};
  assign diff = {1'b0, acc} - {1'b0, operand};

  always_comb begin
    result = acc;
    nextFlags = flags;
    case (ctrl.aluOp)
      ALU_LOAD: result = operand;
      ALU_ADD: begin
        result = sum[`DATA_W-1:0];
        nextFlags.carry = sum[`DATA_W];
        nextFlags.overflow = (accSign == opSign) && (sum[`DATA_W-1] != accSign);
      end
      ALU_SUB: begin
        result = diff[`DATA_W-1:0];
        nextFlags.carry = diff[`DATA_W];
        nextFlags.overflow = (accSign != opSign) && (diff[`DATA_W-1] != accSign);
      end
      ALU_AND: result = acc & operand;
      ALU_OR:  result = acc | operand;
      ALU_INC: result = acc + dataT'(1);
      ALU_DEC: result = acc - dataT'(1);
      ALU_CPL: result = ~acc;
      ALU_ROL: begin
        result = {acc[`DATA_W-2:0], flags.carry}; // Through carry
        nextFlags.carry = accSign;
      end
      ALU_ROR: begin
        result = {flags.carry, acc[`DATA_W-1:1]};
        nextFlags.carry = acc[0];
      end
      ALU_CLR: result = '0;
      ALU_SEC: nextFlags.carry = 1'b1;
      ALU_CLC: nextFlags.carry = 1'b0;
      default: result = acc;
    endcase

    if (ctrl.writesAcc) begin
      nextFlags.zero = (result == '0);
      nextFlags.negative = result[`DATA_W-1];
    end
  end

  always_ff @(posedge CLK) begin
    if (rst) begin
      acc <= '0;
      flags <= '0;
    end else if (exec) begin
      if (ctrl.writesAcc)
        acc <= result;
      flags <= nextFlags;
    end
  end

endmodule

`default_nettype wire

// ==== design/busSequencer.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "cpuMacros.svh"

module busSequencer (
  input  logic            CLK,
  input  logic            rst,
  input  cpuPkg::ctrlT    ctrl,
  input  cpuPkg::flagsT   flags,
  input  cpuPkg::dataT    acc,
  output logic            memReqValid,
  input  logic            memReqReady,
  output cpuPkg::memReqT  memReq,
  input  logic            memRspValid,
  input  cpuPkg::dataT    memRspData,
  output logic            opLoad,
  output logic            exec,
  output cpuPkg::dataT    operand,
  output logic            halted,
  output logic            illegal
);
  import cpuPkg::*;

  seqStateT state;
  addrT     pc;
  addrT     effAddr;
  dataT     lowByte;    // Low address byte or branch offset
  logic     pending;    // Operand read accepted, waiting for data
  logic     reqFire;
  logic     condFlag;
  logic     branchTaken;
  addrT     branchOfs;

  assign reqFire = memReqValid && memReqReady;
  assign operand = memRspData;
  assign halted = (state == HALTED);

  always_comb begin
    memReqValid = 1'b0;
    memReq.addr = pc;
    memReq.wrData = acc;
    memReq.write = 1'b0;
    case (state)
      FETCH:      memReqValid = 1'b1;
      OPLO, OPHI: memReqValid = !pending;
      DATARD: begin
        memReqValid = !pending;
        memReq.addr = effAddr;
      end
      STORE: begin
        memReqValid = 1'b1;
        memReq.addr = effAddr;
        memReq.write = 1'b1;
      end
      default: memReqValid = 1'b0;
    endcase
  end

  always_comb begin
    opLoad = (state == WAITOP) && memRspValid;
    case (state)
      DECODE:  exec = (ctrl.instrClass == CLS_INH);
      OPLO:    exec = memRspValid && (ctrl.instrClass == CLS_IMM);
      DATARD:  exec = memRspValid;
      default: exec = 1'b0;
    endcase
  end

  always_comb begin
    case (ctrl.condSel)
      COND_CARRY: condFlag = flags.carry;
      COND_ZERO:  condFlag = flags.zero;
      COND_NEG:   condFlag = flags.negative;
      default:    condFlag = flags.overflow;
    endcase
  end

  assign branchTaken = (condFlag == ctrl.condPol);
  assign branchOfs = {{(`ADDR_W - `DATA_W){lowByte[`DATA_W-1]}}, lowByte};

  always_ff @(posedge CLK) begin
    if (rst) begin
      state <= DECODE; // Runs the reset NOP, then fetches
      pc <= `RESET_PC;
      pending <= 1'b0;
      illegal <= 1'b0;
    end else begin
      case (state)
        FETCH: begin
          if (reqFire) begin
            pc <= pc + addrT'(1);
            state <= WAITOP;
          end
        end
        WAITOP: begin
          if (memRspValid)
            state <= DECODE;
        end
        DECODE: begin
          case (ctrl.instrClass)
            CLS_INH:  state <= FETCH;
            CLS_HALT: state <= HALTED;
            CLS_ILLEGAL: begin
              illegal <= 1'b1;
              state <= HALTED;
            end
            default:  state <= OPLO;
          endcase
        end
        OPLO, OPHI, DATARD: begin
          if (reqFire) begin
            pending <= 1'b1;
            if (state != DATARD)
              pc <= pc + addrT'(1);
          end
          if (memRspValid) begin
            pending <= 1'b0;
            if (state == DATARD || ctrl.instrClass == CLS_IMM)
              state <= FETCH;
            else if (ctrl.instrClass == CLS_BRANCH)
              state <= BRANCH;
            else if (state == OPLO)
              state <= OPHI;
            else if (ctrl.instrClass == CLS_JMP) begin
              pc <= {memRspData, lowByte};
              state <= FETCH;
            end else if (ctrl.instrClass == CLS_ABSST)
              state <= STORE;
            else
              state <= DATARD;
          end
        end
        STORE: begin
          if (reqFire)
            state <= FETCH; // Writes get no response
        end
        BRANCH: begin
          if (branchTaken)
            pc <= pc + branchOfs; // PC already past the offset
          state <= FETCH;
        end
        default: state <= HALTED;
      endcase
    end
  end

  always_ff @(posedge CLK) begin
    if (state == OPLO && memRspValid)
      lowByte <= memRspData;
    if (state == OPHI && memRspValid)
      effAddr <= {memRspData, lowByte};
  end

endmodule

`default_nettype wire

// ==== design/cpuCore.sv ====
`timescale 1ns/1ns
`default_nettype none

module cpuCore (
  input  logic            CLK,
  input  logic            rst,
  output logic            memReqValid,
  input  logic            memReqReady,
  output cpuPkg::memReqT  memReq,
  input  logic            memRspValid,
  input  cpuPkg::dataT    memRspData,
  output logic            halted,
  output logic            illegal
);
  import cpuPkg::*;

  ctrlT  ctrl;
  flagsT flags;
  dataT  acc;
  dataT  operand;
  logic  opLoad;
  logic  exec;

  // Instruction register and decode
  instrDecode instrDecode_i (
    .CLK    (CLK),
    .rst    (rst),
    .opLoad (opLoad),
    .opByte (memRspData),
    .ctrl   (ctrl)
  );

  aluExecute aluExecute_i (
    .CLK     (CLK),
    .rst     (rst),
    .exec    (exec),
    .operand (operand),
    .ctrl    (ctrl),
    .acc     (acc),
    .flags   (flags)
  );

  // Sequencing, PC and memory handshake
  busSequencer busSequencer_i (
    .CLK         (CLK),
    .rst         (rst),
    .ctrl        (ctrl),
    .flags       (flags),
    .acc         (acc),
    .memReqValid (memReqValid),
    .memReqReady (memReqReady),
    .memReq      (memReq),
    .memRspValid (memRspValid),
    .memRspData  (memRspData),
    .opLoad      (opLoad),
    .exec        (exec),
    .operand     (operand),
    .halted      (halted),
    .illegal     (illegal)
  );

endmodule

`default_nettype wire

// ==== verif/memModel.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "cpuMacros.svh"

module memModel (
  input  logic           CLK,
  input  logic           rst,
  input  logic           memReqValid,
  output logic           memReqReady,
  input  cpuPkg::memReqT memReq,
  output logic           memRspValid,
  output cpuPkg::dataT   memRspData
);
  import cpuPkg::*;

  dataT        mem [0:(1 << `ADDR_W) - 1];
  logic [31:0] rngState;
  int          rspWait;  // Edges left until the response is sampled
  dataT        rspByte;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  initial begin
    rngState = 32'ha6f7_7160;
    rspWait = 0;
    rspByte = '0;
    memReqReady = 1'b0;
    memRspValid = 1'b0;
    memRspData = '0;
    for (int a = 0; a < (1 << `ADDR_W); a++)
      mem[addrT'(a)] = a[15:8] ^ a[7:0] ^ 8'hA5; // Background fill
    forever begin
      @(posedge CLK);
      if (rst) begin
        rspWait = 0;
      end else begin
        if (rspWait > 0)
          rspWait = rspWait - 1;
        if (memReqValid && memReqReady) begin
          if (memReq.write) begin
            mem[memReq.addr] = memReq.wrData;
            $display("%0t memModel write %h <= %h", $time, memReq.addr, memReq.wrData);
          end else begin
            rngState = xorshift32(rngState);
            rspByte = mem[memReq.addr];
            rspWait = 1 + int'(rngState[1:0]); // 1 to 4 cycles
          end
        end
      end
      rngState = xorshift32(rngState);
      #1;
      memReqReady = (rngState[3:2] != 2'b00);
      memRspValid = (rspWait == 1);
      memRspData = (rspWait == 1) ? rspByte : '0;
    end
  end

endmodule

`default_nettype wire

// ==== verif/cpuCoreTb.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "cpuMacros.svh"

module cpuCoreTb;
  import cpuPkg::*;

  localparam int MAX_CYCLES = 4000; // About 60 instructions at up to 12 cycles, plus the second run
  localparam int PROG_LEN = 168;
  localparam int NUM_WRITES = 20;
  localparam addrT FAR_BASE = 16'h1234;
  localparam addrT DATA_BASE = 16'h4C50;

  localparam logic [7:0] MAIN_PROG [0:PROG_LEN-1] = '{
    `OP_LDA_IMM, 8'h3C, `OP_ADD_IMM, 8'h4A, `OP_STA, 8'h00, 8'h9A,
    `OP_SUB_IMM, 8'h07, `OP_STA, 8'h01, 8'h9A,
    `OP_AND_IMM, 8'hF0, `OP_ORA_IMM, 8'h05, `OP_STA, 8'h02, 8'h9A,
    `OP_INA, `OP_CPA, `OP_DCA, `OP_STA, 8'h03, 8'h9A,
    `OP_SEC, `OP_ROL, `OP_ROL, `OP_STA, 8'h04, 8'h9A,   // Rotates through carry
    `OP_ROR, `OP_ROR, `OP_STA, 8'h05, 8'h9A,
    `OP_CLC, `OP_ROR, `OP_STA, 8'h06, 8'h9A,
    `OP_CLA, `OP_STA, 8'h07, 8'h9A,
    `OP_LDA, 8'h50, 8'h4C, `OP_ADD, 8'h51, 8'h4C, `OP_STA, 8'h08, 8'h9A,
    `OP_SUB, 8'h52, 8'h4C, `OP_AND, 8'h50, 8'h4C, `OP_ORA, 8'h52, 8'h4C,
    `OP_STA, 8'h09, 8'h9A, `OP_LDA, 8'h01, 8'h9A, `OP_ADD, 8'h00, 8'h9A,
    `OP_STA, 8'h0A, 8'h9A,                              // C=1 Z=0 N=0 V=0 from here
    `OP_BCS, 8'h03, `OP_STA, 8'hEE, 8'h9A, `OP_BCC, 8'h03, `OP_STA, 8'h0B, 8'h9A,
    `OP_BNE, 8'h03, `OP_STA, 8'hEE, 8'h9A, `OP_BEQ, 8'h03, `OP_STA, 8'h0C, 8'h9A,
    `OP_BPL, 8'h03, `OP_STA, 8'hEE, 8'h9A, `OP_BMI, 8'h03, `OP_STA, 8'h0D, 8'h9A,
    `OP_BVC, 8'h03, `OP_STA, 8'hEE, 8'h9A, `OP_BVS, 8'h03, `OP_STA, 8'h0E, 8'h9A,
    `OP_LDA_IMM, 8'h7F, `OP_ADD_IMM, 8'h01,             // C=0 Z=0 N=1 V=1
    `OP_BCC, 8'h03, `OP_STA, 8'hEE, 8'h9A, `OP_BCS, 8'h03, `OP_STA, 8'h0F, 8'h9A,
    `OP_BMI, 8'h03, `OP_STA, 8'hEE, 8'h9A, `OP_BPL, 8'h03, `OP_STA, 8'h10, 8'h9A,
    `OP_BVS, 8'h03, `OP_STA, 8'hEE, 8'h9A, `OP_BVC, 8'h03, `OP_STA, 8'h11, 8'h9A,
    `OP_LDA_IMM, 8'h03, `OP_DCA, `OP_BNE, 8'hFD,       // Countdown loop, backward branch
    `OP_BEQ, 8'h03, `OP_STA, 8'hEE, 8'h9A, `OP_STA, 8'h12, 8'h9A,
    `OP_JMP, 8'h34, 8'h12, `OP_STA, 8'hEE, 8'h9A
  };
  localparam logic [7:0] FAR_PROG [0:5] = '{`OP_LDA_IMM, 8'hC3, `OP_STA, 8'h13, 8'h9A, `OP_HLT};
  localparam logic [7:0] DATA_BYTES [0:2] = '{8'h5A, 8'h81, 8'h0F};

  // {address, data} in store order
  localparam logic [23:0] EXP_WRITES [0:NUM_WRITES-1] = '{
    24'h9A00_86, 24'h9A01_7F, 24'h9A02_75, 24'h9A03_88, 24'h9A04_23,
    24'h9A05_88, 24'h9A06_44, 24'h9A07_00, 24'h9A08_DB, 24'h9A09_4F,
    24'h9A0A_05, 24'h9A0B_05, 24'h9A0C_05, 24'h9A0D_05, 24'h9A0E_05,
    24'h9A0F_80, 24'h9A10_80, 24'h9A11_80, 24'h9A12_00, 24'h9A13_C3
  };

  logic   CLK = 1'b0;
  logic   rst = 1'b1;
  logic   rstQ = 1'b0;
  logic   memReqValid;
  logic   memReqReady;
  memReqT memReq;
  logic   memRspValid;
  dataT   memRspData;
  logic   halted;
  logic   illegal;
  logic   firstXfer = 1'b1;
  int     writeCount = 0;
  int     cycleCount = 0;

  cpuCore cpuCore_i (
    .CLK         (CLK),
    .rst         (rst),
    .memReqValid (memReqValid),
    .memReqReady (memReqReady),
    .memReq      (memReq),
    .memRspValid (memRspValid),
    .memRspData  (memRspData),
    .halted      (halted),
    .illegal     (illegal)
  );

  memModel memModel_i (
    .CLK         (CLK),
    .rst         (rst),
    .memReqValid (memReqValid),
    .memReqReady (memReqReady),
    .memReq      (memReq),
    .memRspValid (memRspValid),
    .memRspData  (memRspData)
  );

  always #2 CLK = ~CLK;

  task automatic abortRun(input string line);
    $display("%s", line);
    $display("Test failed");
    $fatal(1, "Simulation stopped");
  endtask

  task automatic loadImage();
    for (int i = 0; i < PROG_LEN; i++)
      memModel_i.mem[addrT'(`RESET_PC + i)] = MAIN_PROG[i];
    for (int i = 0; i < 6; i++)
      memModel_i.mem[addrT'(FAR_BASE + i)] = FAR_PROG[i];
    for (int i = 0; i < 3; i++)
      memModel_i.mem[addrT'(DATA_BASE + i)] = DATA_BYTES[i];
  endtask

  task automatic applyReset();
    rst = 1'b1;
    repeat (10) @(posedge CLK);
    #1;
    rst = 1'b0;
  endtask

  task automatic waitHalted();
    do
      @(posedge CLK);
    while (!halted);
  endtask

  always @(posedge CLK) begin
    rstQ <= rst;
    cycleCount <= cycleCount + 1;
    if (cycleCount >= MAX_CYCLES)
      abortRun("Timeout: the CPU did not halt within the cycle limit");
  end

  // First fetch and store sequence
  always @(posedge CLK) begin
    if (rst) begin
      firstXfer <= 1'b1;
    end else if (memReqValid && memReqReady) begin
      firstXfer <= 1'b0;
      if (firstXfer)
        assert (!memReq.write && memReq.addr == `RESET_PC)
          else abortRun($sformatf("ERR %0t: first transfer at %h is not a fetch at reset PC",
                                  $time, memReq.addr));
      if (memReq.write) begin
        assert (writeCount < NUM_WRITES)
          else abortRun($sformatf("ERR %0t: unexpected write to %h", $time, memReq.addr));
        assert (memReq.addr == EXP_WRITES[writeCount][23:8]
                && memReq.wrData == EXP_WRITES[writeCount][7:0])
          else abortRun($sformatf("ERR %0t: write %h=%h, expected %h", $time,
                                  memReq.addr, memReq.wrData, EXP_WRITES[writeCount]));
        writeCount <= writeCount + 1;
      end
    end
  end

  assert property (@(posedge CLK) rstQ |-> !memReqValid && !halted && !illegal)
    else abortRun($sformatf("ERR %0t: request or status high around reset", $time));

  assert property (@(posedge CLK) disable iff (rst)
      memReqValid && !memReqReady |=> memReqValid && $stable(memReq))
    else abortRun($sformatf("ERR %0t: request changed before its transfer", $time));

  assert property (@(posedge CLK) disable iff (rst) halted |-> !memReqValid)
    else abortRun($sformatf("ERR %0t: request issued while halted", $time));

  initial begin
    #1;
    loadImage(); // After the background fill at time 0
    applyReset();
    waitHalted();
    assert (!illegal)
      else abortRun($sformatf("ERR %0t: HLT raised the illegal flag", $time));
    #1;
    memModel_i.mem[`RESET_PC] = 8'h77; // Undefined opcode
    applyReset();
    waitHalted();
    if (illegal && writeCount == NUM_WRITES) begin
      $display("Test passed");
      $finish;
    end else begin
      abortRun($sformatf("End of run: %0d of %0d writes seen, illegal flag %b",
                         writeCount, NUM_WRITES, illegal));
    end
  end

endmodule

`default_nettype wire

// ==== cpuCore.f ====
+incdir+design
design/cpuPkg.sv
design/instrDecode.sv
design/aluExecute.sv
design/busSequencer.sv
design/cpuCore.sv
verif/memModel.sv
verif/cpuCoreTb.sv

// ==== Makefile ====
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation into sim.log and check it"
	@echo "  clean  remove obj_dir and sim.log"

test:
	verilator --binary --timing --assert -f cpuCore.f --top-module cpuCoreTb -o VcpuCoreTb
	./obj_dir/VcpuCoreTb > sim.log 2>&1 || true
	@if grep -q "Test failed" sim.log; then echo "FAIL: see sim.log"; exit 1; fi
	@if ! grep -q "Test passed" sim.log; then echo "FAIL: no pass line in sim.log"; exit 1; fi
	@echo "PASS"

clean:
	rm -rf obj_dir sim.log
